// ==== hdl/exec_pkg.sv ====
package exec_pkg;

	localparam int word_w = 32;

	// data-processing opcodes, insn[24:21].
	typedef enum logic [3:0] {
		op_and, op_eor, op_sub, op_rsb,
		op_add, op_adc, op_sbc, op_rsc,
		op_tst, op_teq, op_cmp, op_cmn,
		op_orr, op_mov, op_bic, op_mvn
	} alu_op_t;

	typedef enum logic [3:0] {
		cls_mult, cls_mrs, cls_msr, cls_msr_flags, cls_swp, cls_bx, cls_hdata,
		cls_alu, cls_ldrstr, cls_ldmstm, cls_branch, cls_coproc, cls_swi, cls_undef
	} insn_class_t;

	// ########################################
	// instruction fields.
	localparam int bit_s       = 20;
	localparam int bit_a       = 21;
	localparam int bit_ps      = 22;
	localparam int bit_l       = 24;
	localparam int bit_msr_all = 16;
	localparam int op_lsb      = 21;
	localparam int rd_lsb      = 12;
	localparam int mul_rd_lsb  = 16; // multiply puts Rd elsewhere.

	// psr flag positions.
	localparam int psr_n = 31;
	localparam int psr_z = 30;
	localparam int psr_c = 29;
	localparam int psr_v = 28;

	localparam logic [4:0] mode_usr = 5'b10000;
	localparam logic [4:0] mode_svc = 5'b10011;
	localparam logic [word_w-1:0] cpsr_reset = {24'h0, 3'b110, mode_svc}; // irq and fiq masked.

	localparam logic [3:0] link_reg = 4'he;
	localparam logic [word_w-1:0] pc_link_off   = 32'd4;
	localparam logic [word_w-1:0] pc_branch_off = 32'd8;

	// ########################################
	// decode patterns in priority order.
	localparam logic [31:0] pat_mult      = 32'b????_0000_00??_????_????_????_1001_????;
	localparam logic [31:0] pat_mrs       = 32'b????_0001_0?00_1111_????_0000_0000_0000;
	localparam logic [31:0] pat_msr       = 32'b????_0001_0?10_1001_1111_0000_0000_????;
	localparam logic [31:0] pat_msr_flags = 32'b????_00?1_0?10_1000_1111_????_????_????;
	localparam logic [31:0] pat_swp       = 32'b????_0001_0?00_????_????_0000_1001_????;
	localparam logic [31:0] pat_bx        = 32'b????_0001_0010_1111_1111_1111_0001_????;
	localparam logic [31:0] pat_hdata     = 32'b????_000?_????_????_????_????_1??1_????;
	localparam logic [31:0] pat_alu       = 32'b????_00??_????_????_????_????_????_????;
	localparam logic [31:0] pat_undef     = 32'b????_011?_????_????_????_????_???1_????;
	localparam logic [31:0] pat_ldrstr    = 32'b????_01??_????_????_????_????_????_????;
	localparam logic [31:0] pat_ldmstm    = 32'b????_100?_????_????_????_????_????_????;
	localparam logic [31:0] pat_branch    = 32'b????_101?_????_????_????_????_????_????;
	localparam logic [31:0] pat_swi       = 32'b????_1111_????_????_????_????_????_????;
	localparam logic [31:0] pat_coproc    = 32'b????_11??_????_????_????_????_????_????;

endpackage

// ==== hdl/psr_if.sv ====
interface psr_if import exec_pkg::*; ();

	logic [word_w-1:0] cpsr;
	logic [word_w-1:0] spsr;
	logic [word_w-1:0] new_cpsr; // full value with unchanged bits passed through.
	logic [word_w-1:0] new_spsr;
	logic psr_up;

	// psr block holds the registers.
	modport owner (output cpsr, spsr, input new_cpsr, new_spsr, psr_up);

	modport user (input cpsr, spsr, output new_cpsr, new_spsr, psr_up);

endinterface

// ==== hdl/insn_classify.sv ====
module insn_classify import exec_pkg::*; (
	input  logic [31:0] insn,
	output insn_class_t cls
);

	// first match wins.
	// multiply and the psr transfers are special cases of the alu space,
	// so they sit ahead of it.
	always_comb begin
		casez (insn)
			pat_mult:
				cls = cls_mult;
			pat_mrs:
				cls = cls_mrs;
			pat_msr:
				cls = cls_msr;
			pat_msr_flags:
				cls = cls_msr_flags;
			pat_swp:
				cls = cls_swp;
			pat_bx:
				cls = cls_bx;
			pat_hdata:
				cls = cls_hdata; // register and immediate offset forms.
			pat_alu:
				cls = cls_alu;
			pat_undef:
				cls = cls_undef; // hole in the load/store space.
			pat_ldrstr:
				cls = cls_ldrstr;
			pat_ldmstm:
				cls = cls_ldmstm;
			pat_branch:
				cls = cls_branch;
			pat_swi:
				cls = cls_swi;
			pat_coproc:
				cls = cls_coproc; // ldc/stc, cdp, mrc/mcr.
			default:
				cls = cls_undef;
		endcase
	end

endmodule

// ==== hdl/alu.sv ====
module alu import exec_pkg::*; (
	input  logic [31:0] in0,
	input  logic [31:0] in1,
	input  alu_op_t op,
	input  logic setflags,
	input  logic shifter_carry,
	input  logic [31:0] cpsr,
	output logic [31:0] result,
	output logic [31:0] cpsr_out,
	output logic setres
);

	logic cin; // carry into adc.
	logic bin; // borrow into sbc and rsc.
	logic [word_w:0] sum;
	logic [word_w:0] diff;
	logic [word_w:0] rdiff;
	logic sum_v, diff_v, rdiff_v;
	logic flag_n, flag_z, flag_c, flag_v;

	assign cin = (op == op_adc) && cpsr[psr_c];
	assign bin = ((op == op_sbc) || (op == op_rsc)) && !cpsr[psr_c];

	assign sum   = {1'b0, in0} + {1'b0, in1} + {{word_w{1'b0}}, cin};
	assign diff  = {1'b0, in0} - {1'b0, in1} - {{word_w{1'b0}}, bin};
	assign rdiff = {1'b0, in1} - {1'b0, in0} - {{word_w{1'b0}}, bin};

	// signed overflow.
	assign sum_v   = (in0[word_w-1] == in1[word_w-1]) && (sum[word_w-1] != in0[word_w-1]);
	assign diff_v  = (in0[word_w-1] != in1[word_w-1]) && (diff[word_w-1] != in0[word_w-1]);
	assign rdiff_v = (in0[word_w-1] != in1[word_w-1]) && (rdiff[word_w-1] != in1[word_w-1]);

	always_comb begin
		flag_c = shifter_carry; // logical ops.
		flag_v = cpsr[psr_v];
		case (op)
			op_and, op_tst:
				result = in0 & in1;
			op_eor, op_teq:
				result = in0 ^ in1;
			op_orr:
				result = in0 | in1;
			op_mov:
				result = in1;
			op_bic:
				result = in0 & ~in1;
			op_mvn:
				result = ~in1;
			op_add, op_adc, op_cmn: begin
				result = sum[word_w-1:0];
				flag_c = sum[word_w];
				flag_v = sum_v;
			end
			op_sub, op_sbc, op_cmp: begin
				result = diff[word_w-1:0];
				flag_c = !diff[word_w]; // arm carry is not-borrow.
				flag_v = diff_v;
			end
			default: begin // rsb, rsc.
				result = rdiff[word_w-1:0];
				flag_c = !rdiff[word_w];
				flag_v = rdiff_v;
			end
		endcase

		flag_n = result[word_w-1];
		flag_z = (result == '0);
		setres = !(op inside {op_tst, op_teq, op_cmp, op_cmn}); // compares only touch flags.

		cpsr_out = cpsr;
		if (setflags)
			cpsr_out[psr_n:psr_v] = {flag_n, flag_z, flag_c, flag_v};
	end

endmodule

// ==== hdl/multiplier.sv ====
module multiplier import exec_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic start,
	input  logic [31:0] acc0,
	input  logic [31:0] in0,
	input  logic [31:0] in1,
	output logic done,
	output logic [31:0] result
);

	logic [word_w-1:0] bits_left; // multiplier bits not yet retired.
	logic [word_w-1:0] mcand;
	logic [word_w-1:0] acc;
	logic [word_w-1:0] partial;

	// two partial products per cycle.
	always_comb begin
		partial = '0;
		if (bits_left[0])
			partial = partial + mcand;
		if (bits_left[1])
			partial = partial + {mcand[word_w-2:0], 1'b0};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			bits_left <= '0;
			done <= 1'b0;
		end else if (start) begin
			bits_left <= in0;
			done <= 1'b0;
		end else begin
			bits_left <= bits_left >> 2;
			if (bits_left == '0)
				done <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			mcand <= in1;
			acc <= acc0;
		end else begin
			mcand <= mcand << 2;
			acc <= acc + partial;
			if (bits_left == '0)
				result <= acc; // nothing left to add.
		end
	end

endmodule

// ==== hdl/psr_file.sv ====
module psr_file import exec_pkg::*; (
	input  logic clk,
	input  logic rst,
	psr_if.owner psr
);

	// ########################################
	// cpsr and spsr.
	//
	// new values arrive complete from the stage,
	// with psr_up already gated by its stall.

	always_ff @(posedge clk) begin
		if (rst) begin
			psr.cpsr <= cpsr_reset; // svc mode with irqs off.
			psr.spsr <= '0;
		end else if (psr.psr_up) begin
			psr.cpsr <= psr.new_cpsr;
			psr.spsr <= psr.new_spsr;
		end
	end

endmodule

// ==== hdl/execute.sv ====
module execute import exec_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic stall,
	input  logic flush,
	input  logic bubble_in,
	input  logic [31:0] pc,
	input  logic [31:0] insn,
	input  logic [31:0] op0,
	input  logic [31:0] op1,
	input  logic [31:0] op2,
	input  logic carry,
	psr_if.user psr,
	output logic stall_out,
	output logic bubble_out,
	output logic write_reg,
	output logic [3:0] write_num,
	output logic [31:0] write_data,
	output logic jmp,
	output logic [31:0] jmppc
);

	insn_class_t cls;
	logic [word_w-1:0] alu_result;
	logic [word_w-1:0] alu_cpsr;
	logic alu_setres;
	logic is_mult;
	logic mult_start, mult_done, mult_wait, mult_stall;
	logic [word_w-1:0] mult_acc0;
	logic [word_w-1:0] mult_result;
	logic flush_pend; // flush seen while stalled.
	logic next_bubble, next_write_reg, next_psr_up;
	logic [3:0] next_write_num;
	logic [word_w-1:0] next_write_data;
	logic flags_only;

	insn_classify classify_i (.insn(insn), .cls(cls));

	alu alu_i (
		.in0(op0), .in1(op1), .op(alu_op_t'(insn[op_lsb +: 4])), .setflags(insn[bit_s]),
		.shifter_carry(carry), .cpsr(psr.cpsr),
		.result(alu_result), .cpsr_out(alu_cpsr), .setres(alu_setres)
	);

	// ########################################
	// multiply control.
	// op0 is Rn, op1 is Rm, op2 is Rs.
	assign is_mult = (cls == cls_mult) && !bubble_in;
	assign mult_start = is_mult && !mult_wait; // one pulse per multiply.
	assign mult_acc0 = insn[bit_a] ? op0 : '0;

	multiplier mult_i (
		.clk(clk), .rst(rst), .start(mult_start), .acc0(mult_acc0), .in0(op1), .in1(op2),
		.done(mult_done), .result(mult_result)
	);

	assign mult_stall = is_mult && !(mult_wait && mult_done);
	assign stall_out = stall || mult_stall;

	always_ff @(posedge clk) begin
		if (rst) begin
			mult_wait <= 1'b0;
			flush_pend <= 1'b0;
		end else begin
			if (mult_start)
				mult_wait <= 1'b1;
			else if (!stall_out)
				mult_wait <= 1'b0; // retired.
			if (flush && stall_out)
				flush_pend <= 1'b1;
			else if (!stall_out)
				flush_pend <= 1'b0;
		end
	end

	// ########################################
	// writeback and psr update.
	assign next_bubble = bubble_in || flush || flush_pend || mult_stall;
	assign flags_only = (psr.cpsr[4:0] == mode_usr) || !insn[bit_msr_all];

	always_comb begin
		next_write_reg = 1'b0;
		next_write_num = insn[rd_lsb +: 4];
		next_write_data = alu_result;
		next_psr_up = 1'b0;
		psr.new_cpsr = psr.cpsr;
		psr.new_spsr = psr.spsr;
		case (cls)
			cls_mult: begin
				next_write_reg = 1'b1;
				next_write_num = insn[mul_rd_lsb +: 4];
				next_write_data = mult_result;
				if (insn[bit_s]) begin // n and z from result, c cleared, v kept.
					psr.new_cpsr[psr_n] = mult_result[word_w-1];
					psr.new_cpsr[psr_z] = (mult_result == '0);
					psr.new_cpsr[psr_c] = 1'b0;
					next_psr_up = 1'b1;
				end
			end
			cls_mrs: begin
				next_write_reg = 1'b1;
				next_write_data = insn[bit_ps] ? psr.spsr : psr.cpsr;
			end
			cls_msr, cls_msr_flags: begin
				next_psr_up = 1'b1;
				if (insn[bit_ps])
					psr.new_spsr = flags_only ? {op0[psr_n:psr_c], psr.spsr[psr_c-1:0]} : op0;
				else
					psr.new_cpsr = flags_only ? {op0[psr_n:psr_c], psr.cpsr[psr_c-1:0]} : op0;
			end
			cls_alu: begin
				next_write_reg = alu_setres;
				if (insn[bit_s]) begin
					next_psr_up = 1'b1;
					// s with rd = pc is an exception return.
					psr.new_cpsr = (insn[rd_lsb +: 4] == 4'hf) ? psr.spsr : alu_cpsr;
				end
			end
			cls_branch: begin
				if (insn[bit_l]) begin
					next_write_reg = 1'b1;
					next_write_num = link_reg;
					next_write_data = pc + pc_link_off;
				end
			end
			default: ; // passes through untouched.
		endcase
	end

	assign psr.psr_up = next_psr_up && !stall_out && !next_bubble;

	// branch resolves in this cycle.
	assign jmppc = pc + op0 + pc_branch_off;
	assign jmp = (cls == cls_branch) && !bubble_in && !flush && !flush_pend && !stall_out;

	always_ff @(posedge clk) begin
		if (rst) begin
			bubble_out <= 1'b1;
			write_reg <= 1'b0;
		end else if (!stall) begin
			bubble_out <= next_bubble;
			write_reg <= next_write_reg && !next_bubble;
		end
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			write_num <= next_write_num;
			write_data <= next_write_data;
		end
	end

endmodule

// ==== hdl/exec_top.sv ====
module exec_top (
	input  logic clk,
	input  logic rst,
	input  logic stall,
	input  logic flush,
	input  logic bubble_in,
	input  logic [31:0] pc,
	input  logic [31:0] insn,
	input  logic [31:0] op0,
	input  logic [31:0] op1,
	input  logic [31:0] op2,
	input  logic carry,
	output logic stall_out,
	output logic bubble_out,
	output logic write_reg,
	output logic [3:0] write_num,
	output logic [31:0] write_data,
	output logic jmp,
	output logic [31:0] jmppc,
	output logic [31:0] cpsr,
	output logic [31:0] spsr
);

	psr_if psr_bus ();

	execute execute_i (
		.clk(clk), .rst(rst), .stall(stall), .flush(flush), .bubble_in(bubble_in),
		.pc(pc), .insn(insn), .op0(op0), .op1(op1), .op2(op2), .carry(carry),
		.psr(psr_bus.user),
		.stall_out(stall_out), .bubble_out(bubble_out), .write_reg(write_reg),
		.write_num(write_num), .write_data(write_data), .jmp(jmp), .jmppc(jmppc)
	);

	psr_file psr_file_i (.clk(clk), .rst(rst), .psr(psr_bus.owner));

	assign cpsr = psr_bus.cpsr; // psr state visible at the top.
	assign spsr = psr_bus.spsr;

endmodule

// ==== testbench/exec_props.sv ====
module exec_props (
	input logic clk,
	input logic rst,
	input logic stall,
	input logic jmp,
	input logic bubble_out,
	input logic write_reg,
	input logic [3:0] write_num,
	input logic [31:0] write_data
);
	timeunit 1ns;
	timeprecision 1ns;

	int fail_cnt = 0; // failed assertions so far.

	// a taken branch leaves the stage on the next edge.
	jmp_retires: assert property (@(posedge clk) disable iff (rst) jmp |=> !bubble_out)
		else begin
			$error("jmp raised for a branch that did not retire");
			fail_cnt++;
		end

	bubble_after_reset: assert property (@(posedge clk) rst |=> bubble_out)
		else begin
			$error("bubble_out low in the cycle after reset");
			fail_cnt++;
		end

	// stage registers hold across a stalled edge.
	hold_on_stall: assert property (@(posedge clk) disable iff (rst)
		stall |=> $stable({bubble_out, write_reg, write_num, write_data}))
		else begin
			$error("outputs changed across a stalled edge");
			fail_cnt++;
		end

endmodule

bind execute exec_props props_i (
	.clk(clk), .rst(rst), .stall(stall), .jmp(jmp),
	.bubble_out(bubble_out), .write_reg(write_reg), .write_num(write_num),
	.write_data(write_data)
);

// ==== testbench/exec_ref.svh ====
`ifndef exec_ref_svh
`define exec_ref_svh

	// ########################################
	// data processing result as {writes, nzcv, result}.
	function automatic logic [36:0] alu_model(input logic [3:0] op, input logic [31:0] a,
			input logic [31:0] b, input logic sc, input logic [3:0] nzcv);
		logic [31:0] r;
		logic [31:0] x;
		logic [31:0] y;
		logic k;
		logic c;
		logic v;
		longint s;
		c = sc; // logical ops take the shifter carry.
		v = nzcv[0];
		x = (op inside {4'h3, 4'h7}) ? b : a; // reverse subtract.
		y = (op inside {4'h3, 4'h7}) ? a : b;
		case (op)
			4'h0, 4'h8: r = a & b;
			4'h1, 4'h9: r = a ^ b;
			4'hc: r = a | b;
			4'hd: r = b;
			4'he: r = a & ~b;
			4'hf: r = ~b;
			4'h4, 4'h5, 4'hb: begin
				k = (op == 4'h5) && nzcv[1];
				s = longint'($signed(a)) + longint'($signed(b)) + longint'(k);
				r = s[31:0];
				c = (64'(a) + 64'(b) + 64'(k)) > 64'hffff_ffff;
				v = (s > 64'sd2147483647) || (s < -64'sd2147483648);
			end
			default: begin // sub, rsb, sbc, rsc, cmp.
				k = (op inside {4'h6, 4'h7}) && !nzcv[1];
				s = longint'($signed(x)) - longint'($signed(y)) - longint'(k);
				r = s[31:0];
				c = 64'(x) >= (64'(y) + 64'(k)); // set when nothing borrowed.
				v = (s > 64'sd2147483647) || (s < -64'sd2147483648);
			end
		endcase
		return {!(op inside {[4'h8:4'hb]}), r[31], (r == 32'h0), c, v, r};
	endfunction

	function automatic logic [31:0] mul_model(input logic [31:0] rm, input logic [31:0] rs,
			input logic [31:0] rn, input logic acc);
		return rm * rs + (acc ? rn : 32'h0);
	endfunction

	// flags form keeps everything below the c bit.
	function automatic logic [31:0] msr_model(input logic [31:0] old, input logic [31:0] val,
			input logic flags_only);
		return flags_only ? {val[31:29], old[28:0]} : val;
	endfunction

	function automatic logic [31:0] branch_target(input logic [31:0] pc_v,
			input logic [31:0] off);
		return pc_v + off + 32'd8;
	endfunction

	function automatic logic [31:0] link_addr(input logic [31:0] pc_v);
		return pc_v + 32'd4;
	endfunction

`endif

// ==== testbench/tb_exec_top.sv ====
module tb_exec_top;
	timeunit 1ns;
	timeprecision 1ns;

	localparam int tests = 400;
	localparam int max_lat = 19;
	localparam int max_cycles = tests * max_lat + 400; // slack for reset and idle.

	logic clk, rst, stall, flush, bubble_in, carry;
	logic [31:0] pc, insn, op0, op1, op2;
	logic stall_out, bubble_out, write_reg, jmp;
	logic [3:0] write_num;
	logic [31:0] write_data, jmppc, cpsr, spsr;

	logic [31:0] exp_cpsr; // psr model.
	logic [31:0] exp_spsr;
	logic [100:0] exp_q[$]; // {write_reg, write_num, write_data, cpsr, spsr}.
	string name_q[$];
	logic [100:0] exp_e;
	string exp_name;
	logic adv;
	int cycles = 0;

	`include "exec_ref.svh"

	exec_top dut_i (.*);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic check_val(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (actual !== expected) begin
			$display("Fail %s: expected %h, actual %h", name, expected, actual);
			$display("test failed");
			$fatal(1, "%s mismatch", name);
		end
	endtask

	task automatic expect_out(input string name, input logic wr, input logic [3:0] num,
			input logic [31:0] data);
		exp_q.push_back({wr, num, data, exp_cpsr, exp_spsr});
		name_q.push_back(name);
	endtask

	// ########################################
	// drive one instruction until it leaves the stage.
	task automatic run(input logic [31:0] w, input logic [31:0] a, input logic [31:0] b,
			input logic [31:0] d, input logic c, input logic bub, input int fc, input int hold);
		int n;
		logic [69:0] held;
		n = 0;
		held = {cpsr, bubble_out, write_reg, write_num, write_data};
		insn = w;
		op0 = a;
		op1 = b;
		op2 = d;
		carry = c;
		bubble_in = bub;
		flush = (fc == 0);
		stall = (hold > 0);
		#1;
		while (stall_out) begin
			@(negedge clk);
			n++;
			if (stall) begin // last edge was held.
				check_val("stall hold data", held[31:0], write_data);
				check_val("stall hold ctl", held[37:32], {bubble_out, write_reg, write_num});
				check_val("stall hold cpsr", held[69:38], cpsr);
			end
			flush = (n == fc);
			stall = (n < hold);
			#1;
		end
		@(negedge clk);
		bubble_in = 1'b1;
		flush = 1'b0;
	endtask

	task automatic alu_insn(input logic [3:0] op, input logic s, input logic [3:0] rd,
			input int hold);
		logic [31:0] a;
		logic [31:0] b;
		logic c;
		logic [36:0] r;
		a = $urandom;
		b = $urandom;
		c = 1'($urandom);
		r = alu_model(op, a, b, c, exp_cpsr[31:28]);
		if (s)
			exp_cpsr = (rd == 4'hf) ? exp_spsr : {r[35:32], exp_cpsr[27:0]}; // pc dest restores.
		expect_out("alu", r[36], rd, r[31:0]);
		run({4'he, 3'b001, op, s, 4'h0, rd, 12'($urandom)}, a, b, 32'h0, c, 1'b0, -1, hold);
	endtask

	task automatic mul_insn(input logic acc, input logic s, input int fc);
		logic [31:0] rn;
		logic [31:0] rm;
		logic [31:0] rs;
		logic [31:0] r;
		logic [3:0] rd;
		rn = $urandom;
		rm = $urandom >> ($urandom % 32); // spread the latency.
		rs = $urandom;
		rd = 4'($urandom);
		r = mul_model(rm, rs, rn, acc);
		if (fc < 0) begin
			if (s)
				exp_cpsr[31:29] = {r[31], (r == 32'h0), 1'b0};
			expect_out("mul", 1'b1, rd, r);
		end
		run({4'he, 6'b000000, acc, s, rd, 4'h1, 4'h2, 4'b1001, 4'h3}, rn, rm, rs, 1'b0, 1'b0,
			fc, 0);
		if (fc >= 0)
			check_val("flushed mul bubble", 32'h1, bubble_out);
	endtask

	task automatic msr_insn(input logic ps, input logic all, input logic [31:0] v);
		logic fo;
		fo = (exp_cpsr[4:0] == 5'b10000) || !all; // user mode only reaches the flags.
		if (ps)
			exp_spsr = msr_model(exp_spsr, v, fo);
		else
			exp_cpsr = msr_model(exp_cpsr, v, fo);
		expect_out("msr", 1'b0, 4'h0, 32'h0);
		run({4'he, 5'b00010, ps, 2'b10, 3'b100, all, 4'hf, 12'h000}, v, 32'h0, 32'h0, 1'b0,
			1'b0, -1, 0);
	endtask

	task automatic mrs_insn(input logic ps, input logic [3:0] rd);
		expect_out("mrs", 1'b1, rd, ps ? exp_spsr : exp_cpsr);
		run({4'he, 5'b00010, ps, 2'b00, 4'hf, rd, 12'h000}, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0,
			-1, 0);
	endtask

	task automatic branch_insn(input logic l, input logic bub, input logic fl);
		logic [31:0] off;
		logic [31:0] w;
		logic taken;
		pc = $urandom;
		off = $urandom;
		w = {4'he, 3'b101, l, 24'($urandom)};
		taken = !bub && !fl;
		insn = w;
		op0 = off;
		bubble_in = bub;
		flush = fl;
		#1;
		check_val("branch jmp", taken, jmp);
		if (taken) begin
			check_val("branch target", branch_target(pc, off), jmppc);
			expect_out("branch", l, 4'he, link_addr(pc));
		end
		run(w, off, 32'h0, 32'h0, 1'b0, bub, fl ? 0 : -1, 0);
		if (!taken)
			check_val("branch bubble", 32'h1, bubble_out);
	endtask

	// ########################################
	// one comparison per retired instruction.
	always @(posedge clk) begin
		adv = !stall;
		#1;
		if (adv && !bubble_out) begin
			if (exp_q.size() == 0) begin
				$display("an output retired with no instruction outstanding");
				$display("test failed");
				$fatal(1, "unexpected output");
			end else begin
				exp_e = exp_q.pop_front();
				exp_name = name_q.pop_front();
				check_val({exp_name, " write_reg"}, exp_e[100], write_reg);
				if (exp_e[100]) begin
					check_val({exp_name, " write_num"}, exp_e[99:96], write_num);
					check_val({exp_name, " write_data"}, exp_e[95:64], write_data);
				end
				check_val({exp_name, " cpsr"}, exp_e[63:32], cpsr);
				check_val({exp_name, " spsr"}, exp_e[31:0], spsr);
			end
		end
	end

	always @(negedge clk) begin
		if (dut_i.execute_i.props_i.fail_cnt != 0) begin
			$display("an assertion on the stage failed");
			$display("test failed");
			$fatal(1, "assertion failure");
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= max_cycles) begin
			$display("run exceeded %0d cycles", max_cycles);
			$display("test failed");
			$fatal(1, "timeout");
		end
	end

	initial begin
		logic [3:0] op;
		void'($urandom(32'hd69d258f));
		rst = 1'b1;
		stall = 1'b0;
		flush = 1'b0;
		bubble_in = 1'b1;
		carry = 1'b0;
		pc = 32'h0;
		insn = 32'h0;
		op0 = 32'h0;
		op1 = 32'h0;
		op2 = 32'h0;
		exp_cpsr = 32'h000000d3;
		exp_spsr = 32'h0;
		repeat (3) @(negedge clk);
		rst = 1'b0;
		check_val("reset cpsr", 32'h000000d3, cpsr);
		check_val("reset spsr", 32'h0, spsr);
		check_val("reset bubble_out", 32'h1, bubble_out);
		check_val("reset write_reg", 32'h0, write_reg);
		check_val("reset stall_out", 32'h0, stall_out);

		repeat (200) begin
			op = 4'($urandom);
			alu_insn(op, (op[3:2] == 2'b10) || 1'($urandom), 4'($urandom % 15), 0);
		end
		repeat (150)
			mul_insn(1'($urandom), 1'($urandom), -1);

		// psr transfers in supervisor then user mode.
		msr_insn(1'b0, 1'b1, {27'($urandom), 5'b10011});
		msr_insn(1'b1, 1'b1, $urandom);
		mrs_insn(1'b0, 4'h1);
		mrs_insn(1'b1, 4'h2);
		msr_insn(1'b0, 1'b0, $urandom);
		msr_insn(1'b0, 1'b1, {27'($urandom), 5'b10000});
		msr_insn(1'b0, 1'b1, $urandom);
		msr_insn(1'b1, 1'b1, $urandom);
		mrs_insn(1'b0, 4'h3);
		mrs_insn(1'b1, 4'h4);
		alu_insn(4'hd, 1'b1, 4'hf, 0); // movs pc.

		branch_insn(1'b0, 1'b0, 1'b0);
		branch_insn(1'b1, 1'b0, 1'b0);
		branch_insn(1'b1, 1'b1, 1'b0);
		branch_insn(1'b1, 1'b0, 1'b1);

		alu_insn(4'h4, 1'b1, 4'h5, 3); // held for three edges.
		mul_insn(1'b1, 1'b0, 1);
		alu_insn(4'h4, 1'b0, 4'h6, 0);

		repeat (2) @(negedge clk);
		check_val("outstanding results", 32'h0, exp_q.size());
		if (dut_i.execute_i.props_i.fail_cnt == 0) begin
			$display("test passed");
			$finish;
		end else begin
			$display("test failed");
			$fatal(1, "an assertion on the stage failed");
		end
	end

endmodule

// ==== tb.f ====
+incdir+testbench
hdl/exec_pkg.sv
hdl/psr_if.sv
hdl/insn_classify.sv
hdl/alu.sv
hdl/multiplier.sv
hdl/psr_file.sv
hdl/execute.sv
hdl/exec_top.sv
testbench/exec_props.sv
testbench/tb_exec_top.sv

// ==== Bender.yml ====
package:
  name: exec_stage

sources:
  - files:
      - hdl/exec_pkg.sv
      - hdl/psr_if.sv
      - hdl/insn_classify.sv
      - hdl/alu.sv
      - hdl/multiplier.sv
      - hdl/psr_file.sv
      - hdl/execute.sv
      - hdl/exec_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/exec_props.sv
      - testbench/tb_exec_top.sv
